//--- filelist.f
cop_isa_pkg.sv
cop_pipe_pkg.sv
cop_dec_if.sv
cop_idecode.sv
cop_instr_fifo.sv
cop_execute.sv
cop_top.sv
tb_cop_checker.sv
tb_cop.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_cop
FILELIST  := filelist.f

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

//--- tb_cop.sv
/*
 * Testbench for cop_top. Issues instructions over the four-phase input
 * port, keeps a model register file and hands each expected writeback
 * to the checker. Every handshake wait gives up after HS_TIMEOUT cycles.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_cop
    import cop_isa_pkg::*;
    import cop_pipe_pkg::*;
();

    localparam int HS_TIMEOUT = 200;

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_req;
    logic        instr_ack;
    logic [31:0] instr;
    logic        wb_req;
    logic        wb_ack;
    logic [3:0]  wb_crd;
    logic [31:0] wb_data;
    logic        wb_exc;
    logic        hold_ack;
    logic        rand_ack;
    logic [31:0] model [16];   // Expected contents of c0 to c15
    int          seed = 87;
    int          issued = 0;
    int          hs_errs = 0;
    int          chk_errs;
    int          wb_seen;

    always #20 clk = ~clk;

    cop_top dut (
        .g_clk_i     (clk),
        .rst_i       (rst),
        .instr_req_i (instr_req),
        .instr_ack_o (instr_ack),
        .instr_i     (instr),
        .wb_req_o    (wb_req),
        .wb_ack_i    (wb_ack),
        .wb_crd_o    (wb_crd),
        .wb_data_o   (wb_data),
        .wb_exc_o    (wb_exc)
    );

    tb_cop_checker chk (
        .clk_i        (clk),
        .rst_i        (rst),
        .hold_i       (hold_ack),
        .rand_delay_i (rand_ack),
        .wb_req_i     (wb_req),
        .wb_ack_o     (wb_ack),
        .wb_crd_i     (wb_crd),
        .wb_data_i    (wb_data),
        .wb_exc_i     (wb_exc),
        .err_count_o  (chk_errs),
        .wb_count_o   (wb_seen)
    );

    function logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    function automatic logic [31:0] reg_form_word(input logic [3:0] fn, input logic [2:0] pw,
                                                  input logic [3:0] rs1, input logic [3:0] rs2,
                                                  input logic [3:0] rd);
        return {fn, pw, rs2, rs1, 6'd0, rd, COP_OPCODE};
    endfunction

    function automatic logic [31:0] imm_form_word(input logic [3:0] fn, input logic [15:0] imm,
                                                  input logic [3:0] rd);
        return {fn, imm, 1'b0, rd, COP_OPCODE};
    endfunction

    // Each lane wraps on its own width
    function automatic logic [31:0] lanewise(input logic [31:0] a, input logic [31:0] b,
                                             input logic sub, input int width);
        logic [63:0] mask;
        logic [63:0] lane;
        logic [31:0] res;
        res  = '0;
        mask = (64'd1 << width) - 64'd1;
        for (int off = 0; off < 32; off += width) begin
            if (sub) begin
                lane = ((64'(a) >> off) & mask) - ((64'(b) >> off) & mask);
            end else begin
                lane = ((64'(a) >> off) & mask) + ((64'(b) >> off) & mask);
            end
            res = res | 32'((lane & mask) << off);
        end
        return res;
    endfunction

    // Reference model, returns {exc, crd, data} for one instruction word
    function automatic logic [36:0] expected_wb(input logic [31:0] w);
        logic [3:0]  fn;
        logic [2:0]  pw;
        logic [3:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] old;
        logic [31:0] data;
        logic        is_packed;
        fn        = w[31:28];
        pw        = w[27:25];
        rd        = w[10:7];
        a         = model[w[20:17]];
        b         = model[w[24:21]];
        old       = model[rd];
        is_packed = (fn == FN_PADD) || (fn == FN_PSUB);
        if ((w[6:0] != COP_OPCODE) || (fn > FN_LI_H) || (is_packed && (pw > 3'd4))) begin
            return {1'b1, 4'd0, 32'd0};
        end
        case (fn)
            FN_PADD: data = lanewise(a, b, 1'b0, 32 >> pw);
            FN_PSUB: data = lanewise(a, b, 1'b1, 32 >> pw);
            FN_LI_L: data = {old[31:16], w[27:12]};
            default: data = {w[27:12], old[15:0]};
        endcase
        return {1'b0, rd, data};
    endfunction

    function logic [31:0] random_word();
        logic [31:0] r;
        logic [31:0] sel;
        r   = next_rand();
        sel = next_rand();
        case (sel[2:0])
            3'd0, 3'd1: return reg_form_word(FN_PADD, r[2:0] % 3'd5, r[6:3], r[10:7], r[14:11]);
            3'd2, 3'd3: return reg_form_word(FN_PSUB, r[2:0] % 3'd5, r[6:3], r[10:7], r[14:11]);
            3'd4:       return imm_form_word(FN_LI_L, r[31:16], r[14:11]);
            3'd5:       return imm_form_word(FN_LI_H, r[31:16], r[14:11]);
            3'd6:       return reg_form_word(FN_PADD, r[2:0], r[6:3], r[10:7], r[14:11]);
            default:    return r;   // Mostly a wrong opcode
        endcase
    endfunction

    task automatic wait_ack(input logic level, input string name);
        int n;
        n = 0;
        while (instr_ack !== level && n < HS_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (instr_ack !== level) begin
            $display("Timeout in %s: instr_ack_o never went to %0b", name, level);
            hs_errs++;
        end
    endtask

    task automatic raise_req(input logic [31:0] w, input string name);
        logic [36:0] exp;
        exp = expected_wb(w);
        if (!exp[36]) begin
            model[w[10:7]] = exp[31:0];
        end
        chk.push_expected(name, exp);
        issued++;
        @(posedge clk);
        instr     <= w;
        instr_req <= 1'b1;
    endtask

    task automatic finish_handshake(input string name);
        wait_ack(1'b1, name);
        instr_req <= 1'b0;
        wait_ack(1'b0, name);
    endtask

    task automatic send_word(input logic [31:0] w, input string name);
        raise_req(w, name);
        finish_handshake(name);
    endtask

    task automatic wait_drain(input string name);
        int n;
        n = 0;
        while (wb_seen != issued && n < HS_TIMEOUT * 8) begin
            @(posedge clk);
            n++;
        end
        if (wb_seen != issued) begin
            $display("Timeout in %s: %0d writebacks never arrived", name, issued - wb_seen);
            hs_errs++;
        end
    endtask

    initial begin
        logic [31:0] w;
        logic        stalled;
        rst       = 1'b1;
        instr_req = 1'b0;
        instr     = '0;
        hold_ack  = 1'b0;
        rand_ack  = 1'b0;
        for (int i = 0; i < 16; i++) begin
            model[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Quiet ports after reset
        repeat (20) begin
            @(posedge clk);
            if (instr_ack || wb_req) begin
                $display("Handshake became active after reset with no stimulus");
                hs_errs++;
            end
        end

        for (int r = 0; r < 16; r++) begin
            w = next_rand();
            send_word(imm_form_word(FN_LI_L, w[15:0], 4'(r)), "li_low");
            send_word(imm_form_word(FN_LI_H, w[31:16], 4'(r)), "li_high");
            w = next_rand();
            send_word(imm_form_word(FN_LI_L, w[15:0], 4'(r)), "li_low_keeps_high");
        end
        wait_drain("load_immediate");

        for (int pw = 0; pw < 5; pw++) begin
            for (int k = 0; k < 6; k++) begin
                w = next_rand();
                send_word(reg_form_word(FN_PADD, 3'(pw), w[3:0], w[7:4], w[11:8]), "packed_add");
                send_word(reg_form_word(FN_PSUB, 3'(pw), w[15:12], w[19:16], w[23:20]),
                          "packed_sub");
            end
        end
        wait_drain("packed_arith");

        // c0 cleared so that c5 + c0 reads c5 back
        send_word(imm_form_word(FN_LI_L, 16'h0, 4'd0), "clear_c0");
        send_word(imm_form_word(FN_LI_H, 16'h0, 4'd0), "clear_c0");
        w      = imm_form_word(FN_LI_L, 16'hbeef, 4'd5);
        w[6:0] = 7'h33;
        send_word(w, "bad_opcode");
        send_word(imm_form_word(4'h9, 16'hbeef, 4'd5), "bad_funct");
        for (int pw = 5; pw < 8; pw++) begin
            send_word(reg_form_word(FN_PSUB, 3'(pw), 4'd1, 4'd2, 4'd5), "bad_pack_width");
        end
        send_word(reg_form_word(FN_PADD, PW_32, 4'd5, 4'd0, 4'd5), "readback_after_illegal");
        wait_drain("illegal");

        // Executor, queue and decoder all full
        hold_ack <= 1'b1;
        for (int k = 0; k < int'(FIFO_DEPTH) + 2; k++) begin
            w = next_rand();
            send_word(imm_form_word(k[0] ? FN_LI_H : FN_LI_L, w[15:0], 4'(k + 6)),
                      "backpressure");
        end
        raise_req(imm_form_word(FN_LI_L, 16'h1234, 4'd12), "backpressure_stalled");
        stalled = 1'b1;
        repeat (20) begin
            @(posedge clk);
            if (instr_ack) begin
                stalled = 1'b0;
            end
        end
        if (!stalled) begin
            $display("Decoder accepted an instruction while the pipeline was full");
            hs_errs++;
        end
        hold_ack <= 1'b0;
        finish_handshake("backpressure_stalled");
        wait_drain("backpressure");

        rand_ack <= 1'b1;
        for (int k = 0; k < 200; k++) begin
            send_word(random_word(), "random_mix");
        end
        wait_drain("random_mix");

        $display("Errors: %0d in writeback compare, %0d in handshake", chk_errs, hs_errs);
        if (chk_errs == 0 && hs_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_cop_checker.sv
/*
 * Writeback side of the testbench. Drives wb_ack_i, compares every
 * writeback with the oldest expected entry and counts mismatches.
 * Expected entries are pushed by the testbench before issue.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_cop_checker (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        hold_i,         // Keeps ack low, stalls the executor
    input  logic        rand_delay_i,   // Random ack delay of 0 to 4 cycles
    input  logic        wb_req_i,
    output logic        wb_ack_o,
    input  logic [3:0]  wb_crd_i,
    input  logic [31:0] wb_data_i,
    input  logic        wb_exc_i,
    output int          err_count_o,
    output int          wb_count_o
);

    localparam int REQ_TIMEOUT = 200;

    logic [36:0] exp_q [$];    // {exc, crd, data}
    string       name_q [$];
    logic        ack_q = 1'b0;
    int          state = 0;    // 0 idle, 1 delaying ack, 2 ack high
    int          delay = 0;
    int          wait_cnt = 0;
    int          errs = 0;
    int          seen = 0;
    int          seed = 87;

    task automatic push_expected(input string name, input logic [36:0] exp);
        exp_q.push_back(exp);
        name_q.push_back(name);
    endtask

    // Returns 1 on a mismatch or an unexpected writeback
    function automatic int check_wb();
        logic [36:0] exp;
        string       name;
        if (exp_q.size() == 0) begin
            $display("Unexpected writeback to c%0d, no instruction outstanding", wb_crd_i);
            return 1;
        end
        exp  = exp_q.pop_front();
        name = name_q.pop_front();
        if (exp === {wb_exc_i, wb_crd_i, wb_data_i}) begin
            return 0;
        end
        $display("Fail %s: expected exc=%0b crd=%0d data=%08h, actual exc=%0b crd=%0d data=%08h",
                 name, exp[36], exp[35:32], exp[31:0], wb_exc_i, wb_crd_i, wb_data_i);
        return 1;
    endfunction

    always @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            state <= 0;
        end else begin
            case (state)
                0: if (wb_req_i) begin
                    errs  <= errs + check_wb();
                    seen  <= seen + 1;
                    delay <= rand_delay_i ? int'($unsigned($random(seed)) % 5) : 0;
                    state <= 1;
                end
                1: if (!hold_i) begin
                    if (delay == 0) begin
                        ack_q    <= 1'b1;
                        wait_cnt <= 0;
                        state    <= 2;
                    end else begin
                        delay <= delay - 1;
                    end
                end
                default: if (!wb_req_i) begin
                    ack_q <= 1'b0;
                    state <= 0;
                end else if (wait_cnt == REQ_TIMEOUT) begin
                    $display("Timeout: wb_req_o stayed high after the writeback ack");
                    errs  <= errs + 1;
                    ack_q <= 1'b0;
                    state <= 0;
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            endcase
        end
    end

    assign wb_ack_o    = ack_q;
    assign err_count_o = errs;
    assign wb_count_o  = seen;

endmodule

`default_nettype wire

//--- cop_top.sv
/*
 * Coprocessor front end: decoder, instruction queue and executor.
 * Both external ports are four-phase req/ack, one writeback per
 * instruction including illegal ones, in issue order.
 */
`timescale 1ns/10ps
`default_nettype none

module cop_top (
    input  logic        g_clk_i,
    input  logic        rst_i,
    input  logic        instr_req_i,
    output logic        instr_ack_o,
    input  logic [31:0] instr_i,
    output logic        wb_req_o,
    input  logic        wb_ack_i,
    output logic [3:0]  wb_crd_o,
    output logic [31:0] wb_data_o,
    output logic        wb_exc_o
);

    cop_dec_if dec_to_q ();
    cop_dec_if q_to_ex ();

    cop_idecode u_idecode (
        .g_clk_i     (g_clk_i),
        .rst_i       (rst_i),
        .instr_req_i (instr_req_i),
        .instr_ack_o (instr_ack_o),
        .instr_i     (instr_i),
        .out_o       (dec_to_q.src)
    );

    cop_instr_fifo u_instr_fifo (
        .g_clk_i (g_clk_i),
        .rst_i   (rst_i),
        .in_i    (dec_to_q.dst),
        .out_o   (q_to_ex.src)
    );

    cop_execute u_execute (
        .g_clk_i   (g_clk_i),
        .rst_i     (rst_i),
        .in_i      (q_to_ex.dst),
        .wb_req_o  (wb_req_o),
        .wb_ack_i  (wb_ack_i),
        .wb_crd_o  (wb_crd_o),
        .wb_data_o (wb_data_o),
        .wb_exc_o  (wb_exc_o)
    );

endmodule

`default_nettype wire

//--- cop_execute.sv
/*
 * Executor with sixteen 32-bit registers, all cleared by reset.
 * One instruction at a time: the next one is taken only after the
 * writeback handshake has fully completed.
 */
`timescale 1ns/10ps
`default_nettype none

module cop_execute
    import cop_isa_pkg::*;
    import cop_pipe_pkg::*;
(
    input  logic        g_clk_i,
    input  logic        rst_i,
    cop_dec_if.dst      in_i,
    output logic        wb_req_o,
    input  logic        wb_ack_i,
    output logic [3:0]  wb_crd_o,
    output logic [31:0] wb_data_o,
    output logic        wb_exc_o
);

    logic [31:0] regs_q [16];
    cop_uop_t    uop_q;
    logic        in_ack_q;
    logic        exec_q;      // Operation and write happen this cycle
    logic        wb_wait_q;   // Waiting for wb_ack_i to fall
    logic        take;
    logic [31:0] rd_old;
    logic [31:0] result;

    // Lane-wise add or subtract, carry restarts at every lane boundary
    function automatic logic [31:0] lane_addsub(
        input logic [31:0] a,
        input logic [31:0] b,
        input logic        sub,
        input cop_pw_e     pw
    );
        logic [31:0] bx;
        logic [4:0]  lane_msk;
        logic        cy;
        logic [31:0] res;
        bx       = sub ? ~b : b;
        lane_msk = 5'b11111 >> pw;   // Lane width minus one
        cy       = sub;
        for (int i = 0; i < 32; i++) begin
            if ((5'(i) & lane_msk) == 5'd0) begin
                cy = sub;
            end
            res[i] = a[i] ^ bx[i] ^ cy;
            cy     = (a[i] & bx[i]) | (cy & (a[i] ^ bx[i]));
        end
        return res;
    endfunction

    assign take   = in_i.req && !in_ack_q && !exec_q && !wb_req_o && !wb_wait_q;
    assign rd_old = regs_q[uop_q.crd];

    always_comb begin
        case (uop_q.funct)
            FN_PADD: result = lane_addsub(regs_q[uop_q.crs1], regs_q[uop_q.crs2], 1'b0, uop_q.pw);
            FN_PSUB: result = lane_addsub(regs_q[uop_q.crs1], regs_q[uop_q.crs2], 1'b1, uop_q.pw);
            FN_LI_L: result = {rd_old[31:16], uop_q.imm};
            FN_LI_H: result = {uop_q.imm, rd_old[15:0]};
            default: result = '0;
        endcase
    end

    always_ff @(posedge g_clk_i) begin
        if (rst_i) begin
            in_ack_q  <= 1'b0;
            exec_q    <= 1'b0;
            wb_req_o  <= 1'b0;
            wb_wait_q <= 1'b0;
        end else begin
            if (take) begin
                in_ack_q <= 1'b1;
            end else if (in_ack_q && !in_i.req) begin
                in_ack_q <= 1'b0;
            end
            exec_q <= take;
            if (exec_q) begin
                wb_req_o <= 1'b1;
            end else if (wb_req_o && wb_ack_i) begin
                wb_req_o  <= 1'b0;
                wb_wait_q <= 1'b1;
            end
            if (wb_wait_q && !wb_ack_i) begin
                wb_wait_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge g_clk_i) begin
        if (rst_i) begin
            regs_q <= '{default: '0};
        end else if (exec_q && !uop_q.illegal) begin
            regs_q[uop_q.crd] <= result;
        end
    end

    always_ff @(posedge g_clk_i) begin
        if (take) begin
            uop_q <= in_i.uop;
        end
        if (exec_q) begin
            wb_crd_o  <= uop_q.illegal ? 4'd0 : uop_q.crd;
            wb_data_o <= uop_q.illegal ? 32'd0 : result;
            wb_exc_o  <= uop_q.illegal;
        end
    end

    assign in_i.ack = in_ack_q;

    // Previous writeback must be fully closed before a new one starts
    a_wb_rise: assert property (@(posedge g_clk_i) disable iff (rst_i)
        $rose(wb_req_o) |-> !wb_ack_i)
        else $error("wb_req_o rose with wb_ack_i high");

endmodule

`default_nettype wire

//--- cop_instr_fifo.sv
/*
 * Circular queue of FIFO_DEPTH decoded instructions.
 * Sink side acks on store, source side presents the head entry and
 * retires it only once the executor has dropped its ack.
 */
`timescale 1ns/10ps
`default_nettype none

module cop_instr_fifo
    import cop_pipe_pkg::*;
(
    input  logic    g_clk_i,
    input  logic    rst_i,
    cop_dec_if.dst  in_i,
    cop_dec_if.src  out_o
);

    cop_uop_t              mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wptr_q;
    logic [FIFO_PTR_W-1:0] rptr_q;
    logic [FIFO_CNT_W-1:0] count_q;
    logic                  in_ack_q;
    logic                  out_req_q;
    logic                  out_busy_q;   // Head handed out, waiting for ack low
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
    assign push = in_i.req && !in_ack_q && !full;
    assign pop  = out_busy_q && !out_req_q && !out_o.ack;

    always_ff @(posedge g_clk_i) begin
        if (push) begin
            mem_q[wptr_q] <= in_i.uop;
        end
    end

    always_ff @(posedge g_clk_i) begin
        if (rst_i) begin
            wptr_q     <= '0;
            rptr_q     <= '0;
            count_q    <= '0;
            in_ack_q   <= 1'b0;
            out_req_q  <= 1'b0;
            out_busy_q <= 1'b0;
        end else begin
            if (push) begin
                wptr_q   <= wptr_q + 1'b1;
                in_ack_q <= 1'b1;
            end else if (in_ack_q && !in_i.req) begin
                in_ack_q <= 1'b0;
            end
            if (out_req_q && out_o.ack) begin
                out_req_q <= 1'b0;
            end else if (!out_busy_q && (count_q != '0)) begin
                out_req_q  <= 1'b1;
                out_busy_q <= 1'b1;
            end
            if (pop) begin
                out_busy_q <= 1'b0;
                rptr_q     <= rptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    assign in_i.ack  = in_ack_q;
    assign out_o.req = out_req_q;
    assign out_o.uop = mem_q[rptr_q];

    a_count_max: assert property (@(posedge g_clk_i) disable iff (rst_i)
        count_q <= FIFO_CNT_W'(FIFO_DEPTH))
        else $error("queue count above depth");

    a_no_req_empty: assert property (@(posedge g_clk_i) disable iff (rst_i)
        out_o.req |-> (count_q != '0))
        else $error("queue requesting while empty");

endmodule

`default_nettype wire

//--- cop_idecode.sv
/*
 * Registered decoder. Accepts a new word only while the outbound
 * handshake is fully idle, so it holds at most one decoded instruction.
 * Reserved fields of the word are ignored.
 */
`timescale 1ns/10ps
`default_nettype none

module cop_idecode
    import cop_isa_pkg::*;
    import cop_pipe_pkg::*;
(
    input  logic        g_clk_i,
    input  logic        rst_i,
    input  logic        instr_req_i,
    output logic        instr_ack_o,
    input  logic [31:0] instr_i,
    cop_dec_if.src      out_o
);

    cop_instr_u instr_q;     // Captured word, read in both forms
    logic       out_req_q;
    logic       accept;
    logic       packed_op;
    logic       bad_funct;
    cop_uop_t   uop;

    assign accept = instr_req_i && !instr_ack_o && !out_req_q && !out_o.ack;

    always_ff @(posedge g_clk_i) begin
        if (accept) begin
            instr_q <= instr_i;
        end
    end

    always_ff @(posedge g_clk_i) begin
        if (rst_i) begin
            instr_ack_o <= 1'b0;
            out_req_q   <= 1'b0;
        end else begin
            if (accept) begin
                instr_ack_o <= 1'b1;
            end else if (instr_ack_o && !instr_req_i) begin
                instr_ack_o <= 1'b0;
            end
            if (accept) begin
                out_req_q <= 1'b1;          // Uop valid from the same edge
            end else if (out_req_q && out_o.ack) begin
                out_req_q <= 1'b0;
            end
        end
    end

    // Field selection by function
    always_comb begin
        uop       = '0;
        packed_op = 1'b0;
        bad_funct = 1'b0;
        uop.funct = instr_q.iform.funct;
        uop.crd   = instr_q.iform.crd;
        uop.pw    = PW_32;
        case (instr_q.iform.funct)
            FN_PADD, FN_PSUB: begin
                packed_op = 1'b1;
                uop.pw    = instr_q.rform.pw;
                uop.crs1  = instr_q.rform.crs1;
                uop.crs2  = instr_q.rform.crs2;
            end
            FN_LI_L, FN_LI_H: begin
                uop.imm = instr_q.iform.imm16;
            end
            default: bad_funct = 1'b1;
        endcase
        uop.illegal = (instr_q.rform.opcode != COP_OPCODE) || bad_funct ||
                      (packed_op && (instr_q.rform.pw > PW_2));
    end

    assign out_o.req = out_req_q;
    assign out_o.uop = uop;

    // Queue must see the same uop for the whole request
    a_uop_stable: assert property (@(posedge g_clk_i) disable iff (rst_i)
        (out_o.req && $past(out_o.req)) |-> $stable(out_o.uop))
        else $error("decoder changed uop during request");

endmodule

`default_nettype wire

//--- cop_dec_if.sv
/*
 * One decoded instruction with a four-phase req/ack.
 * The source holds uop stable from req rise until ack has fallen.
 */
`timescale 1ns/10ps
`default_nettype none

interface cop_dec_if
    import cop_pipe_pkg::*;
();
    logic     req;
    logic     ack;
    cop_uop_t uop;

    modport src (
        output req,
        output uop,
        input  ack
    );

    modport dst (
        input  req,
        input  uop,
        output ack
    );

endinterface

`default_nettype wire

//--- cop_pipe_pkg.sv
/*
 * Decoded instruction passed between decoder, queue and executor.
 * FIFO_DEPTH must stay a power of two, the pointers wrap freely.
 */
`default_nettype none

package cop_pipe_pkg;
    import cop_isa_pkg::*;

    localparam int unsigned FIFO_DEPTH = 4;
    localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef struct packed {
        cop_funct_e  funct;
        cop_pw_e     pw;       // Only meaningful for packed ops
        logic [3:0]  crs1;
        logic [3:0]  crs2;
        logic [3:0]  crd;
        logic [15:0] imm;      // Only meaningful for load-immediate
        logic        illegal;  // Executor reports an exception, no write
    } cop_uop_t;

endpackage

`default_nettype wire

//--- cop_isa_pkg.sv
/*
 * Coprocessor instruction encoding, limited to packed add/sub and the two
 * load-immediate halves. Reserved fields are not checked by the decoder.
 */
`default_nettype none

package cop_isa_pkg;

    // Major opcode shared by every coprocessor instruction (custom-0)
    localparam logic [6:0] COP_OPCODE = 7'b0001011;

    // Function field, bits 31:28
    typedef enum logic [3:0] {
        FN_PADD = 4'h0,   // Packed add
        FN_PSUB = 4'h1,   // Packed subtract
        FN_LI_L = 4'h2,   // Load immediate into low half
        FN_LI_H = 4'h3    // Load immediate into high half
    } cop_funct_e;

    // Pack width codes, 5 to 7 are illegal for packed arithmetic
    typedef enum logic [2:0] {
        PW_32 = 3'd0,
        PW_16 = 3'd1,
        PW_8  = 3'd2,
        PW_4  = 3'd3,
        PW_2  = 3'd4
    } cop_pw_e;

    // Register form, used by packed arithmetic
    typedef struct packed {
        cop_funct_e funct;    // 31:28
        cop_pw_e    pw;       // 27:25
        logic [3:0] crs2;     // 24:21
        logic [3:0] crs1;     // 20:17
        logic [5:0] rsvd;     // 16:11
        logic [3:0] crd;      // 10:7
        logic [6:0] opcode;   // 6:0
    } cop_rform_t;

    // Immediate form, used by the load-immediate pair
    typedef struct packed {
        cop_funct_e  funct;   // 31:28
        logic [15:0] imm16;   // 27:12
        logic        rsvd;    // 11
        logic [3:0]  crd;     // 10:7
        logic [6:0]  opcode;  // 6:0
    } cop_iform_t;

    // Funct, crd and opcode sit in the same bits in both forms
    typedef union packed {
        cop_rform_t rform;
        cop_iform_t iform;
    } cop_instr_u;

endpackage

`default_nettype wire
